//--- verilog/colmix_pkg.sv
// colour mixer shared types
// widths, pixel and program port structs

package colmix_pkg;

    localparam int PRIO_AW = 5;   // priority PROM address bits
    localparam int PRIO_DW = 8;   // priority PROM word
    localparam int PAL_AW  = 8;   // palette index / palette PROM address
    localparam int COL_W   = 4;   // one colour channel
    localparam int PIX_DLY = 2;   // pixel path depth before the output stage

    // layer select, low two bits of the priority word
    localparam logic [1:0] SEL_CHAR = 2'd3;
    localparam logic [1:0] SEL_OBJ  = 2'd2;
    localparam logic [1:0] SEL_SCR1 = 2'd1;
    localparam logic [1:0] SEL_SCR2 = 2'd0;

    // one pixel from each layer, 21 bits
    typedef struct packed {
        logic [3:0] char_code;
        logic [3:0] scr1_code;
        logic [4:0] scr2_code;
        logic [7:0] obj_code;     // msb is the object priority bit
    } layer_pxl_t;

    // PROM program port, 20 bits
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
        logic [2:0] rgb_we;       // 0 red, 1 green, 2 blue
        logic       prio_we;
    } prom_wr_t;

    typedef struct packed {
        logic [COL_W-1:0] red;
        logic [COL_W-1:0] green;
        logic [COL_W-1:0] blue;
    } rgb_t;

    // both active low
    typedef struct packed {
        logic lhbl;
        logic lvbl;
    } blank_t;

    // debug layer enables
    typedef struct packed {
        logic char_en;
        logic scr1_en;
        logic scr2_en;
        logic obj_en;
    } layer_en_t;

endpackage

//--- verilog/colmix_prom.sv
// small synchronous PROM
`timescale 1ns/10ps

module colmix_prom #(
    parameter int  AW     = 8,
    parameter type data_t = logic [7:0]
) (
    input  logic          clk,
    input  logic          cen,
    input  logic [AW-1:0] wr_addr,
    input  data_t         wr_data,
    input  logic          we,
    input  logic [AW-1:0] rd_addr,
    output data_t         q
);

    data_t mem [2**AW];   // filled through the program port

    // write port free running, independent of the pixel strobe
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, q holds while cen is low
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

    // once the read address has come out of reset it must stay known
    property p_rd_addr_known;
        @(posedge clk) disable iff ($isunknown(cen))
        (cen && !$isunknown($past(rd_addr))) |-> !$isunknown(rd_addr);
    endproperty

    a_rd_addr_known: assert property (p_rd_addr_known)
        else $error("colmix_prom: unknown read address on enabled read");

endmodule

//--- verilog/layer_priority.sv
// layer priority and palette index
`timescale 1ns/10ps

module layer_priority (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  colmix_pkg::layer_pxl_t        pxl,
    input  colmix_pkg::layer_en_t         gfx_en,
    input  colmix_pkg::prom_wr_t          prom_wr,
    output logic [colmix_pkg::PAL_AW-1:0] pal_idx
);

    logic char_op;   // opaque flags
    logic scr1_op;
    logic scr2_op;
    logic obj_op;
    logic [colmix_pkg::PRIO_AW-1:0] prio_addr;
    logic [colmix_pkg::PRIO_AW-1:0] prio_addr_q;
    logic [colmix_pkg::PRIO_AW-1:0] prio_rd_addr;
    logic [colmix_pkg::PRIO_DW-1:0] prio_word;
    colmix_pkg::layer_pxl_t         pxl_q;     // codes of the sampled pixel
    logic                           primed;    // first pixel seen
    logic [1:0]                     sel;
    logic [4:0]                     code;

    // colour 15 is see-through, a cleared enable hides the layer
    assign char_op = gfx_en.char_en && (pxl.char_code != 4'hf);
    assign scr1_op = gfx_en.scr1_en && (pxl.scr1_code != 4'hf);
    assign scr2_op = gfx_en.scr2_en && (pxl.scr2_code[3:0] != 4'hf);
    assign obj_op  = gfx_en.obj_en  && (pxl.obj_code[3:0] != 4'hf);

    assign prio_addr = {char_op, pxl.obj_code[7], obj_op, scr1_op, scr2_op};

    // live address on the strobe, held address otherwise
    // so the PROM word stays with the sampled pixel until the next strobe
    assign prio_rd_addr = pxl_cen ? prio_addr : prio_addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio_addr_q <= '0;
            primed      <= 1'b0;
        end else if (pxl_cen) begin
            prio_addr_q <= prio_addr;
            primed      <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pxl_q <= pxl;   // codes travel alongside the PROM read
        end
    end

    // priority PROM, read every clock
    colmix_prom #(
        .AW     (colmix_pkg::PRIO_AW),
        .data_t (logic [colmix_pkg::PRIO_DW-1:0])
    ) i_prio_prom (
        .clk     (clk),
        .cen     (1'b1),
        .wr_addr (prom_wr.addr[colmix_pkg::PRIO_AW-1:0]),
        .wr_data (prom_wr.data),
        .we      (prom_wr.prio_we),
        .rd_addr (prio_rd_addr),
        .q       (prio_word)
    );

    assign sel = prio_word[1:0];   // upper bits unused by this board

    always_comb begin
        case (sel)
            colmix_pkg::SEL_CHAR: code = {1'b0, pxl_q.char_code};
            colmix_pkg::SEL_OBJ:  code = pxl_q.obj_code[4:0];   // prio bit dropped
            colmix_pkg::SEL_SCR1: code = {1'b0, pxl_q.scr1_code};
            default:              code = pxl_q.scr2_code;
        endcase
    end

    // index is zero until a pixel has gone through
    assign pal_idx = primed ? {sel, 1'b0, code} : '0;

endmodule

//--- verilog/palette_lookup.sv
// palette PROMs
`timescale 1ns/10ps

module palette_lookup (
    input  logic                          clk,
    input  logic                          pxl_cen,
    input  logic [colmix_pkg::PAL_AW-1:0] pal_idx,
    input  colmix_pkg::prom_wr_t          prom_wr,
    output colmix_pkg::rgb_t              pre_rgb
);

    logic [colmix_pkg::COL_W-1:0] chan_q [3];   // 0 red, 1 green, 2 blue

    // one PROM per channel, same index, own write enable
    for (genvar i = 0; i < 3; i++) begin : g_chan
        colmix_prom #(
            .AW     (colmix_pkg::PAL_AW),
            .data_t (logic [colmix_pkg::COL_W-1:0])
        ) i_pal_prom (
            .clk     (clk),
            .cen     (pxl_cen),                               // read once per pixel
            .wr_addr (prom_wr.addr),
            .wr_data (prom_wr.data[colmix_pkg::COL_W-1:0]),   // low nibble only
            .we      (prom_wr.rgb_we[i]),
            .rd_addr (pal_idx),
            .q       (chan_q[i])
        );
    end

    assign pre_rgb.red   = chan_q[0];
    assign pre_rgb.green = chan_q[1];
    assign pre_rgb.blue  = chan_q[2];

endmodule

//--- verilog/blank_align.sv
// blanking delay line
`timescale 1ns/10ps

module blank_align (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pxl_cen,
    input  colmix_pkg::blank_t  blank_in,
    output colmix_pkg::blank_t  blank_dly
);

    colmix_pkg::blank_t dly_q [colmix_pkg::PIX_DLY];   // one slot per pixel stage

    // shifts only on the strobe, same as the pixel path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < colmix_pkg::PIX_DLY; i++) begin
                dly_q[i] <= '0;   // blanked
            end
        end else if (pxl_cen) begin
            dly_q[0] <= blank_in;
            for (int i = 1; i < colmix_pkg::PIX_DLY; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign blank_dly = dly_q[colmix_pkg::PIX_DLY-1];

    // an unknown strobe would skew this line against the PROM reads
    a_cen_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(pxl_cen)
    ) else $error("blank_align: pxl_cen unknown");

endmodule

//--- verilog/video_out.sv
// video output register
`timescale 1ns/10ps

module video_out (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pxl_cen,
    input  colmix_pkg::rgb_t    pre_rgb,
    input  colmix_pkg::blank_t  blank_dly,
    output colmix_pkg::rgb_t    rgb,
    output colmix_pkg::blank_t  blank_out
);

    logic visible;

    assign visible = blank_dly.lhbl && blank_dly.lvbl;   // both active low

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb       <= '0;
            blank_out <= '0;   // out of reset the screen is blanked
        end else if (pxl_cen) begin
            rgb       <= visible ? pre_rgb : '0;   // black in the borders
            blank_out <= blank_dly;
        end
    end

    // an unprogrammed palette entry must not reach the screen
    a_rgb_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pxl_cen && visible) |-> !$isunknown(pre_rgb)
    ) else $error("video_out: unknown colour on a visible pixel");

endmodule

//--- verilog/colmix_top.sv
// colour mixer top
`timescale 1ns/10ps

module colmix_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  colmix_pkg::layer_pxl_t pxl,
    input  colmix_pkg::blank_t     blank_in,
    input  colmix_pkg::layer_en_t  gfx_en,
    input  colmix_pkg::prom_wr_t   prom_wr,
    output colmix_pkg::rgb_t       rgb,
    output colmix_pkg::blank_t     blank_out
);

    logic [colmix_pkg::PAL_AW-1:0] pal_idx;
    colmix_pkg::rgb_t              pre_rgb;
    colmix_pkg::blank_t            blank_dly;

    // pixel path, stage 1
    layer_priority i_layer_priority (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .pxl     (pxl),
        .gfx_en  (gfx_en),
        .prom_wr (prom_wr),
        .pal_idx (pal_idx)
    );

    // pixel path, stage 2
    palette_lookup i_palette_lookup (
        .clk     (clk),
        .pxl_cen (pxl_cen),
        .pal_idx (pal_idx),
        .prom_wr (prom_wr),
        .pre_rgb (pre_rgb)
    );

    // matches the two pixel stages
    blank_align i_blank_align (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .blank_in  (blank_in),
        .blank_dly (blank_dly)
    );

    video_out i_video_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .pre_rgb   (pre_rgb),
        .blank_dly (blank_dly),
        .rgb       (rgb),
        .blank_out (blank_out)
    );

endmodule

//--- tests/colmix_checks.svh
// compare tasks, lcg and test bookkeeping
`ifndef COLMIX_CHECKS_SVH
`define COLMIX_CHECKS_SVH

logic [31:0] lcg_state = 32'd2;   // seed
logic [2:0]  cur_test  = 3'd0;
int          check_cnt = 0;
int          fail_cnt  = 0;
int          chk_start = 0;   // counts at test start
int          fail_start = 0;

// 32-bit lcg, upper middle bits are the better ones
function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
endfunction

function automatic string test_name(input logic [2:0] id);
    case (id)
        3'd0:    return "reset";
        3'd1:    return "priority";
        3'd2:    return "transparency";
        3'd3:    return "palette";
        3'd4:    return "blanking";
        3'd5:    return "strobe_gaps";
        default: return "random";
    endcase
endfunction

task automatic check_rgb(input string name, input colmix_pkg::rgb_t expected,
                         input colmix_pkg::rgb_t actual);
    check_cnt++;
    if (actual !== expected) begin
        fail_cnt++;
        $display("[FAIL] %s expected rgb %h actual %h", name, expected, actual);
    end
endtask

task automatic check_blank(input string name, input colmix_pkg::blank_t expected,
                           input colmix_pkg::blank_t actual);
    check_cnt++;
    if (actual !== expected) begin
        fail_cnt++;
        $display("[FAIL] %s expected blank %b actual %b", name, expected, actual);
    end
endtask

task automatic start_test(input logic [2:0] id);
    cur_test   = id;
    chk_start  = check_cnt;
    fail_start = fail_cnt;
endtask

task automatic end_test();
    $display("test %s: %0d checks, %0d failures", test_name(cur_test),
             check_cnt - chk_start, fail_cnt - fail_start);
endtask

`endif

//--- tests/colmix_tb.sv
// colour mixer testbench
`timescale 1ns/10ps

module colmix_tb;

    localparam int LOAD_CYC    = 32 + 3 * 256;   // one clock per PROM write
    localparam int N_STROBES   = 64 + 64 + 3 * 2 + 16 + 40 + 300 + 10 * 3;   // flushes too
    localparam int MAX_SPACING = 5;              // widest strobe gap plus one
    localparam int CYCLE_LIMIT = 4 + LOAD_CYC + N_STROBES * MAX_SPACING + 1000;

    localparam colmix_pkg::blank_t    VISIBLE = 2'b11;
    localparam colmix_pkg::blank_t    BLANKED = 2'b00;
    localparam colmix_pkg::layer_en_t ALL_EN  = 4'hf;

    // one expected output per strobe
    typedef struct packed {
        colmix_pkg::rgb_t   rgb;
        colmix_pkg::blank_t blank;
        logic               chk;       // flush pixels are not compared
        logic [2:0]         test_id;
    } exp_t;

    logic                   clk;
    logic                   rst_n;
    logic                   pxl_cen;
    colmix_pkg::layer_pxl_t pxl;
    colmix_pkg::blank_t     blank_in;
    colmix_pkg::layer_en_t  gfx_en;
    colmix_pkg::prom_wr_t   prom_wr;
    colmix_pkg::rgb_t       rgb;
    colmix_pkg::blank_t     blank_out;

    logic [7:0]                   prio_sh  [32];    // shadow of the priority PROM
    logic [colmix_pkg::COL_W-1:0] red_sh   [256];
    logic [colmix_pkg::COL_W-1:0] green_sh [256];
    logic [colmix_pkg::COL_W-1:0] blue_sh  [256];
    exp_t exp_q [$];
    int   push_cnt   = 0;
    int   pop_cnt    = 0;
    int   strobe_cnt = 0;
    int   cyc        = 0;

    `include "colmix_checks.svh"

    colmix_top i_colmix_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .pxl       (pxl),
        .blank_in  (blank_in),
        .gfx_en    (gfx_en),
        .prom_wr   (prom_wr),
        .rgb       (rgb),
        .blank_out (blank_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 100 MHz
    end

    // opacity, priority address and index rules
    function automatic logic [7:0] ref_index(input colmix_pkg::layer_pxl_t p,
                                             input colmix_pkg::layer_en_t en);
        logic [4:0] a;
        logic [1:0] s;
        logic [4:0] c;
        a[4] = en.char_en && (p.char_code != 4'hf);
        a[3] = p.obj_code[7];
        a[2] = en.obj_en && (p.obj_code[3:0] != 4'hf);
        a[1] = en.scr1_en && (p.scr1_code != 4'hf);
        a[0] = en.scr2_en && (p.scr2_code[3:0] != 4'hf);
        s = prio_sh[a][1:0];
        case (s)
            2'd3:    c = {1'b0, p.char_code};
            2'd2:    c = p.obj_code[4:0];
            2'd1:    c = {1'b0, p.scr1_code};
            default: c = p.scr2_code;
        endcase
        return {s, 1'b0, c};
    endfunction

    function automatic colmix_pkg::rgb_t ref_rgb(input colmix_pkg::layer_pxl_t p,
                                                 input colmix_pkg::layer_en_t en,
                                                 input colmix_pkg::blank_t b);
        colmix_pkg::rgb_t r;
        logic [7:0]       idx;
        idx     = ref_index(p, en);
        r.red   = red_sh[idx];
        r.green = green_sh[idx];
        r.blue  = blue_sh[idx];
        if (!(b.lhbl && b.lvbl)) r = '0;   // black while blanked
        return r;
    endfunction

    function automatic logic [3:0] opaque_nibble();
        logic [15:0] r;
        r = lcg_next();
        return (r[3:0] == 4'hf) ? 4'h0 : r[3:0];
    endfunction

    // pixel whose opacity pattern is the given priority address
    function automatic colmix_pkg::layer_pxl_t addr_pixel(input logic [4:0] a);
        colmix_pkg::layer_pxl_t p;
        logic [15:0]            r;
        r = lcg_next();
        p.char_code = a[4] ? opaque_nibble() : 4'hf;
        p.obj_code  = {a[3], r[2:0], a[2] ? opaque_nibble() : 4'hf};
        p.scr1_code = a[1] ? opaque_nibble() : 4'hf;
        p.scr2_code = {r[3], a[0] ? opaque_nibble() : 4'hf};
        return p;
    endfunction

    task automatic write_prom(input logic [7:0] addr, input logic [7:0] data,
                              input logic [2:0] rgb_we, input logic prio_we);
        prom_wr.addr    = addr;
        prom_wr.data    = data;
        prom_wr.rgb_we  = rgb_we;
        prom_wr.prio_we = prio_we;
        if (rgb_we[0]) red_sh[addr]   = data[3:0];   // low nibble only
        if (rgb_we[1]) green_sh[addr] = data[3:0];
        if (rgb_we[2]) blue_sh[addr]  = data[3:0];
        if (prio_we)   prio_sh[addr[4:0]] = data;
        @(posedge clk);
        #1;
        prom_wr = '0;
    endtask

    task automatic load_proms();
        logic [15:0] r;
        for (int i = 0; i < 32; i++) begin
            r = lcg_next();
            write_prom(8'(i), r[7:0], 3'b000, 1'b1);
        end
        for (int i = 0; i < 256; i++) begin
            for (int c = 0; c < 3; c++) begin
                r = lcg_next();   // each channel its own data
                write_prom(8'(i), r[7:0], 3'b001 << c, 1'b0);
            end
        end
    endtask

    // one strobe, then gap idle clocks; entered and left 1 ns after an edge
    task automatic drive_pixel(input colmix_pkg::layer_pxl_t p, input colmix_pkg::layer_en_t en,
                               input colmix_pkg::blank_t b, input logic chk, input int gap);
        exp_t e;
        pxl       = p;
        gfx_en    = en;
        blank_in  = b;
        pxl_cen   = 1'b1;
        e.rgb     = ref_rgb(p, en, b);
        e.blank   = b;
        e.chk     = chk;
        e.test_id = cur_test;
        exp_q.push_back(e);
        push_cnt++;
        @(posedge clk);
        #1;
        pxl_cen = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // strobe blanked pixels until every pixel sent so far is compared
    task automatic drain_pipe();
        int target;
        target = push_cnt;
        while (pop_cnt < target) begin
            drive_pixel('0, ALL_EN, BLANKED, 1'b0, 0);
        end
    endtask

    initial begin : main
        colmix_pkg::layer_pxl_t p;
        colmix_pkg::layer_en_t  en;
        colmix_pkg::blank_t     b;
        logic [31:0]            w;
        logic [15:0]            r;
        logic [15:0]            m;
        logic [7:0]             idx;
        rst_n    = 1'b0;
        pxl_cen  = 1'b0;
        pxl      = '0;
        blank_in = BLANKED;
        gfx_en   = ALL_EN;
        prom_wr  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test(3'd0);
        check_rgb("reset", '0, rgb);       // blanked out of reset
        check_blank("reset", BLANKED, blank_out);
        load_proms();
        end_test();

        start_test(3'd1);   // every opacity pattern twice, both obj prio bits
        for (int a = 0; a < 64; a++) begin
            drive_pixel(addr_pixel(a[4:0]), ALL_EN, VISIBLE, 1'b1, 0);
        end
        drain_pipe();
        end_test();

        start_test(3'd2);
        for (int i = 0; i < 64; i++) begin
            w = {lcg_next(), lcg_next()};
            p = w[20:0];
            m = lcg_next();
            if (m[0]) p.char_code = 4'hf;   // forced transparent
            if (m[1]) p.scr1_code = 4'hf;
            if (m[2]) p.scr2_code[3:0] = 4'hf;
            if (m[3]) p.obj_code[3:0] = 4'hf;
            en = m[7:4];                    // cleared enables hide layers
            drive_pixel(p, en, VISIBLE, 1'b1, 0);
        end
        drain_pipe();
        end_test();

        start_test(3'd3);
        for (int c = 0; c < 3; c++) begin
            w   = {lcg_next(), lcg_next()};
            p   = w[20:0];
            idx = ref_index(p, ALL_EN);
            r   = lcg_next();
            write_prom(idx, r[7:0], 3'b001 << c, 1'b0);   // one channel only
            repeat (2) drive_pixel(p, ALL_EN, VISIBLE, 1'b1, 0);
            drain_pipe();
        end
        end_test();

        start_test(3'd4);
        for (int i = 0; i < 16; i++) begin
            w      = {lcg_next(), lcg_next()};
            b.lhbl = i[1];
            b.lvbl = i[0];
            drive_pixel(w[20:0], ALL_EN, b, 1'b1, 0);
        end
        drain_pipe();
        end_test();

        start_test(3'd5);
        for (int i = 0; i < 40; i++) begin
            w = {lcg_next(), lcg_next()};
            r = lcg_next();
            drive_pixel(w[20:0], ALL_EN, VISIBLE, 1'b1, int'(r[1:0]) + int'(r[2]));
        end
        drain_pipe();
        end_test();

        start_test(3'd6);
        for (int i = 0; i < 300; i++) begin
            w      = {lcg_next(), lcg_next()};
            r      = lcg_next();
            en     = r[3:0] | r[7:4];          // mostly enabled
            b.lhbl = (r[10:8] != 3'd0);        // mostly visible
            b.lvbl = (r[13:11] != 3'd0);
            drive_pixel(w[20:0], en, b, 1'b1, 0);
        end
        drain_pipe();
        end_test();

        $display("total: %0d checks, %0d failures", check_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // scoreboard, sampled at the falling edge after each rising edge
    initial begin : compare
        exp_t               e;
        logic               strobe;
        colmix_pkg::rgb_t   last_rgb;
        colmix_pkg::blank_t last_blank;
        last_rgb   = '0;
        last_blank = '0;
        forever begin
            @(posedge clk);
            strobe = pxl_cen;   // inputs change 1 ns later
            @(negedge clk);
            if (strobe) begin
                strobe_cnt++;
                if (strobe_cnt < 3) begin   // pipeline still holds reset state
                    check_rgb("reset", '0, rgb);
                    check_blank("reset", BLANKED, blank_out);
                end else if (exp_q.size() == 0) begin
                    fail_cnt++;
                    $display("compare queue was empty when a result was due");
                end else begin
                    e = exp_q.pop_front();
                    pop_cnt++;
                    if (e.chk) begin
                        check_rgb(test_name(e.test_id), e.rgb, rgb);
                        check_blank(test_name(e.test_id), e.blank, blank_out);
                    end
                end
                last_rgb   = rgb;
                last_blank = blank_out;
            end else if (strobe_cnt > 0) begin   // no strobe, outputs must hold
                check_rgb("hold", last_rgb, rgb);
                check_blank("hold", last_blank, blank_out);
            end
        end
    end

    initial begin : watchdog
        while (cyc < CYCLE_LIMIT) begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- flist.f
+incdir+tests
verilog/colmix_pkg.sv
verilog/colmix_prom.sv
verilog/layer_priority.sv
verilog/palette_lookup.sv
verilog/blank_align.sv
verilog/video_out.sv
verilog/colmix_top.sv
tests/colmix_tb.sv

//--- run.sh
#!/bin/sh
# build and run the colour mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f flist.f --top-module colmix_tb -o colmix_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/colmix_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "pass message not found"
exit 1
